/* rtl/wb_pkg.sv */
/*
  Shared definitions for the memory and write-back back end:
  widths, write-back source codes and load/store size codes
*/

package wb_pkg;

  // Default data width of the pipeline
  parameter int DEFAULT_XLEN = 32;

  // Register index into either register file
  typedef logic [4:0] reg_addr_t;

  // Integer write-back source select
  typedef logic [2:0] wb_sel_t;

  localparam wb_sel_t WB_ALU    = 3'd0;
  localparam wb_sel_t WB_MEM    = 3'd1;
  localparam wb_sel_t WB_PC4    = 3'd2;
  localparam wb_sel_t WB_MULDIV = 3'd3;
  localparam wb_sel_t WB_FPINT  = 3'd4;

  // Load/store size, same encoding as RISC-V funct3
  typedef logic [2:0] mem_size_t;

  localparam mem_size_t SIZE_B  = 3'd0;
  localparam mem_size_t SIZE_H  = 3'd1;
  localparam mem_size_t SIZE_W  = 3'd2;
  localparam mem_size_t SIZE_BU = 3'd4;
  localparam mem_size_t SIZE_HU = 3'd5;

  // FP exception flags, ordered NV DZ OF UF NX from bit 4 down to bit 0
  typedef logic [4:0] fflags_t;

endpackage

/* rtl/mem_stage.sv */
/*
  Memory stage: small data memory with byte, halfword and word stores,
  and loads that sign- or zero-extend the addressed data
*/

`timescale 1ns/1ps

module mem_stage #(
  parameter int XLEN       = 32,
  parameter int DMEM_WORDS = 64
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  valid,
  input  logic                  mem_read,
  input  logic                  mem_write,
  input  wb_pkg::mem_size_t     mem_size,
  input  logic [XLEN-1:0]       addr,
  input  logic [XLEN-1:0]       store_data,
  output logic [XLEN-1:0]       mem_read_data
);

  localparam int NBYTES = XLEN / 8;
  localparam int OFF_W  = $clog2(NBYTES);
  localparam int IDX_W  = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]   mem [DMEM_WORDS];

  logic [IDX_W-1:0]  word_idx;
  logic [OFF_W-1:0]  byte_off;
  logic [OFF_W-1:0]  lane_off;
  logic [NBYTES-1:0] size_mask;
  logic [NBYTES-1:0] wr_mask;
  logic [XLEN-1:0]   wr_data;
  logic [XLEN-1:0]   lane_word;

  // Word index wraps around the memory size
  assign word_idx = IDX_W'((addr >> OFF_W) % DMEM_WORDS);
  assign byte_off = addr[OFF_W-1:0];

  // Offset rounded down to the access size, and the lanes it covers
  always_comb begin
    case (mem_size)
      wb_pkg::SIZE_B, wb_pkg::SIZE_BU: begin
        lane_off  = byte_off;
        size_mask = NBYTES'(1);
      end
      wb_pkg::SIZE_H, wb_pkg::SIZE_HU: begin
        lane_off  = byte_off & ~OFF_W'(1);
        size_mask = NBYTES'(3);
      end
      wb_pkg::SIZE_W: begin
        lane_off  = byte_off & ~OFF_W'(3);
        size_mask = NBYTES'(15);
      end
      default: begin
        lane_off  = '0;
        size_mask = '1;
      end
    endcase
  end

  assign wr_mask = size_mask << lane_off;
  assign wr_data = store_data << {lane_off, 3'b000};

  // Only the enabled byte lanes of the addressed word change
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (valid && mem_write) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (wr_mask[b]) begin
          mem[word_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // Addressed data moved down to bit 0 before extension
  assign lane_word = mem[word_idx] >> {lane_off, 3'b000};

  always_comb begin
    if (!mem_read) begin
      mem_read_data = '0;
    end else begin
      case (mem_size)
        wb_pkg::SIZE_B:  mem_read_data = XLEN'($signed(lane_word[7:0]));
        wb_pkg::SIZE_BU: mem_read_data = XLEN'(lane_word[7:0]);
        wb_pkg::SIZE_H:  mem_read_data = XLEN'($signed(lane_word[15:0]));
        wb_pkg::SIZE_HU: mem_read_data = XLEN'(lane_word[15:0]);
        wb_pkg::SIZE_W:  mem_read_data = XLEN'($signed(lane_word[31:0]));
        default:         mem_read_data = lane_word;
      endcase
    end
  end

endmodule

/* rtl/memwb_register.sv */
/*
  MEM/WB pipeline register
  Holds the memory-stage results for one cycle on their way to write-back
*/

`timescale 1ns/1ps

module memwb_register #(
  parameter int XLEN = 32
) (
  input  logic               clk,
  input  logic               reset_n,

  // From the memory stage
  input  logic [XLEN-1:0]    alu_result_in,
  input  logic [XLEN-1:0]    mem_read_data_in,
  input  logic [XLEN-1:0]    pc_plus_4_in,
  input  logic [XLEN-1:0]    mul_div_result_in,
  input  logic [XLEN-1:0]    fp_result_in,
  input  logic [XLEN-1:0]    int_result_fp_in,
  input  wb_pkg::reg_addr_t  rd_addr_in,
  input  wb_pkg::reg_addr_t  fp_rd_addr_in,
  input  logic               reg_write_in,
  input  logic               fp_reg_write_in,
  input  logic               valid_in,
  input  wb_pkg::wb_sel_t    wb_sel_in,
  input  wb_pkg::fflags_t    fp_flags_in,

  // To the write-back stage
  output logic [XLEN-1:0]    alu_result_out,
  output logic [XLEN-1:0]    mem_read_data_out,
  output logic [XLEN-1:0]    pc_plus_4_out,
  output logic [XLEN-1:0]    mul_div_result_out,
  output logic [XLEN-1:0]    fp_result_out,
  output logic [XLEN-1:0]    int_result_fp_out,
  output wb_pkg::reg_addr_t  rd_addr_out,
  output wb_pkg::reg_addr_t  fp_rd_addr_out,
  output logic               reg_write_out,
  output logic               fp_reg_write_out,
  output logic               valid_out,
  output wb_pkg::wb_sel_t    wb_sel_out,
  output wb_pkg::fflags_t    fp_flags_out
);

  // Last stage never stalls, so every field loads each cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      alu_result_out     <= '0;
      mem_read_data_out  <= '0;
      pc_plus_4_out      <= '0;
      mul_div_result_out <= '0;
      fp_result_out      <= '0;
      int_result_fp_out  <= '0;
      rd_addr_out        <= '0;
      fp_rd_addr_out     <= '0;
      reg_write_out      <= 1'b0;
      fp_reg_write_out   <= 1'b0;
      valid_out          <= 1'b0;
      wb_sel_out         <= '0;
      fp_flags_out       <= '0;
    end else begin
      alu_result_out     <= alu_result_in;
      mem_read_data_out  <= mem_read_data_in;
      pc_plus_4_out      <= pc_plus_4_in;
      mul_div_result_out <= mul_div_result_in;
      fp_result_out      <= fp_result_in;
      int_result_fp_out  <= int_result_fp_in;
      rd_addr_out        <= rd_addr_in;
      fp_rd_addr_out     <= fp_rd_addr_in;
      reg_write_out      <= reg_write_in;
      fp_reg_write_out   <= fp_reg_write_in;
      valid_out          <= valid_in;
      wb_sel_out         <= wb_sel_in;
      fp_flags_out       <= fp_flags_in;
    end
  end

endmodule

/* rtl/wb_stage.sv */
/*
  Write-back stage: picks the integer result source, drives both
  register-file write ports and keeps the sticky FP exception flags
*/

`timescale 1ns/1ps

module wb_stage #(
  parameter int XLEN = 32
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               fflags_clear,
  input  logic               valid,
  input  logic               reg_write,
  input  logic               fp_reg_write,
  input  wb_pkg::wb_sel_t    wb_sel,
  input  wb_pkg::reg_addr_t  rd_addr,
  input  wb_pkg::reg_addr_t  fp_rd_addr,
  input  logic [XLEN-1:0]    alu_result,
  input  logic [XLEN-1:0]    mem_read_data,
  input  logic [XLEN-1:0]    pc_plus_4,
  input  logic [XLEN-1:0]    mul_div_result,
  input  logic [XLEN-1:0]    fp_result,
  input  logic [XLEN-1:0]    int_result_fp,
  input  wb_pkg::fflags_t    fp_flags,
  output logic               int_we,
  output wb_pkg::reg_addr_t  int_waddr,
  output logic [XLEN-1:0]    int_wdata,
  output logic               fp_we,
  output wb_pkg::reg_addr_t  fp_waddr,
  output logic [XLEN-1:0]    fp_wdata,
  output wb_pkg::fflags_t    fflags
);

  // Integer result source, unknown codes write zero
  always_comb begin
    case (wb_sel)
      wb_pkg::WB_ALU:    int_wdata = alu_result;
      wb_pkg::WB_MEM:    int_wdata = mem_read_data;
      wb_pkg::WB_PC4:    int_wdata = pc_plus_4;
      wb_pkg::WB_MULDIV: int_wdata = mul_div_result;
      wb_pkg::WB_FPINT:  int_wdata = int_result_fp;
      default:           int_wdata = '0;
    endcase
  end

  assign int_we    = valid && reg_write;
  assign int_waddr = rd_addr;

  // FLW takes the load data, everything else the FP unit result
  assign fp_we    = valid && fp_reg_write;
  assign fp_waddr = fp_rd_addr;
  assign fp_wdata = (wb_sel == wb_pkg::WB_MEM) ? mem_read_data : fp_result;

  // Sticky flags; a clear beats a same-cycle accumulation
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags <= '0;
    end else if (fflags_clear) begin
      fflags <= '0;
    end else if (valid && fp_reg_write) begin
      fflags <= fflags | fp_flags;
    end
  end

endmodule

/* rtl/reg_file.sv */
/*
  Register file, 32 entries, one write port and one combinational read port
  Entry 0 can be tied to zero for the integer file
*/

`timescale 1ns/1ps

module reg_file #(
  parameter int XLEN     = 32,
  parameter bit ZERO_REG = 1'b1
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               we,
  input  wb_pkg::reg_addr_t  waddr,
  input  logic [XLEN-1:0]    wdata,
  input  wb_pkg::reg_addr_t  raddr,
  output logic [XLEN-1:0]    rdata
);

  logic [XLEN-1:0] regs [32];
  logic            wr_allowed;

  // x0 stays zero when the file has a hardwired zero register
  assign wr_allowed = we && !(ZERO_REG && (waddr == '0));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_allowed) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata = regs[raddr];

endmodule

/* rtl/mem_wb_top.sv */
/*
  Back end of the pipeline: memory stage, MEM/WB register, write-back
  stage, and the integer and FP register files
*/

`timescale 1ns/1ps

module mem_wb_top #(
  parameter int XLEN       = wb_pkg::DEFAULT_XLEN,
  parameter int DMEM_WORDS = 64
) (
  input  logic               clk,
  input  logic               reset_n,

  // One instruction from the execute stage
  input  logic               in_valid,
  input  logic [XLEN-1:0]    alu_result,
  input  logic [XLEN-1:0]    store_data,
  input  logic               mem_read,
  input  logic               mem_write,
  input  wb_pkg::mem_size_t  mem_size,
  input  wb_pkg::reg_addr_t  rd_addr,
  input  logic               reg_write,
  input  wb_pkg::wb_sel_t    wb_sel,
  input  logic [XLEN-1:0]    pc_plus_4,
  input  logic [XLEN-1:0]    mul_div_result,
  input  logic [XLEN-1:0]    fp_result,
  input  logic [XLEN-1:0]    int_result_fp,
  input  wb_pkg::reg_addr_t  fp_rd_addr,
  input  logic               fp_reg_write,
  input  wb_pkg::fflags_t    fp_flags,

  input  logic               fflags_clear,

  // Observation ports
  input  wb_pkg::reg_addr_t  int_rs_addr,
  output logic [XLEN-1:0]    int_rs_data,
  input  wb_pkg::reg_addr_t  fp_rs_addr,
  output logic [XLEN-1:0]    fp_rs_data,
  output wb_pkg::fflags_t    fflags
);

  logic [XLEN-1:0]    mem_read_data;

  logic [XLEN-1:0]    wb_alu_result;
  logic [XLEN-1:0]    wb_mem_read_data;
  logic [XLEN-1:0]    wb_pc_plus_4;
  logic [XLEN-1:0]    wb_mul_div_result;
  logic [XLEN-1:0]    wb_fp_result;
  logic [XLEN-1:0]    wb_int_result_fp;
  wb_pkg::reg_addr_t  wb_rd_addr;
  wb_pkg::reg_addr_t  wb_fp_rd_addr;
  logic               wb_reg_write;
  logic               wb_fp_reg_write;
  logic               wb_valid;
  wb_pkg::wb_sel_t    wb_wb_sel;
  wb_pkg::fflags_t    wb_fp_flags;

  logic               int_we;
  wb_pkg::reg_addr_t  int_waddr;
  logic [XLEN-1:0]    int_wdata;
  logic               fp_we;
  wb_pkg::reg_addr_t  fp_waddr;
  logic [XLEN-1:0]    fp_wdata;

  mem_stage #(
    .XLEN       (XLEN),
    .DMEM_WORDS (DMEM_WORDS)
  ) u_mem_stage (
    .clk           (clk),
    .reset_n       (reset_n),
    .valid         (in_valid),
    .mem_read      (mem_read),
    .mem_write     (mem_write),
    .mem_size      (mem_size),
    .addr          (alu_result),
    .store_data    (store_data),
    .mem_read_data (mem_read_data)
  );

  memwb_register #(
    .XLEN (XLEN)
  ) u_memwb_register (
    .clk                (clk),
    .reset_n            (reset_n),
    .alu_result_in      (alu_result),
    .mem_read_data_in   (mem_read_data),
    .pc_plus_4_in       (pc_plus_4),
    .mul_div_result_in  (mul_div_result),
    .fp_result_in       (fp_result),
    .int_result_fp_in   (int_result_fp),
    .rd_addr_in         (rd_addr),
    .fp_rd_addr_in      (fp_rd_addr),
    .reg_write_in       (reg_write),
    .fp_reg_write_in    (fp_reg_write),
    .valid_in           (in_valid),
    .wb_sel_in          (wb_sel),
    .fp_flags_in        (fp_flags),
    .alu_result_out     (wb_alu_result),
    .mem_read_data_out  (wb_mem_read_data),
    .pc_plus_4_out      (wb_pc_plus_4),
    .mul_div_result_out (wb_mul_div_result),
    .fp_result_out      (wb_fp_result),
    .int_result_fp_out  (wb_int_result_fp),
    .rd_addr_out        (wb_rd_addr),
    .fp_rd_addr_out     (wb_fp_rd_addr),
    .reg_write_out      (wb_reg_write),
    .fp_reg_write_out   (wb_fp_reg_write),
    .valid_out          (wb_valid),
    .wb_sel_out         (wb_wb_sel),
    .fp_flags_out       (wb_fp_flags)
  );

  wb_stage #(
    .XLEN (XLEN)
  ) u_wb_stage (
    .clk            (clk),
    .reset_n        (reset_n),
    .fflags_clear   (fflags_clear),
    .valid          (wb_valid),
    .reg_write      (wb_reg_write),
    .fp_reg_write   (wb_fp_reg_write),
    .wb_sel         (wb_wb_sel),
    .rd_addr        (wb_rd_addr),
    .fp_rd_addr     (wb_fp_rd_addr),
    .alu_result     (wb_alu_result),
    .mem_read_data  (wb_mem_read_data),
    .pc_plus_4      (wb_pc_plus_4),
    .mul_div_result (wb_mul_div_result),
    .fp_result      (wb_fp_result),
    .int_result_fp  (wb_int_result_fp),
    .fp_flags       (wb_fp_flags),
    .int_we         (int_we),
    .int_waddr      (int_waddr),
    .int_wdata      (int_wdata),
    .fp_we          (fp_we),
    .fp_waddr       (fp_waddr),
    .fp_wdata       (fp_wdata),
    .fflags         (fflags)
  );

  // Integer file keeps x0 at zero, FP file has a writable f0
  reg_file #(
    .XLEN     (XLEN),
    .ZERO_REG (1'b1)
  ) int_regs (
    .clk     (clk),
    .reset_n (reset_n),
    .we      (int_we),
    .waddr   (int_waddr),
    .wdata   (int_wdata),
    .raddr   (int_rs_addr),
    .rdata   (int_rs_data)
  );

  reg_file #(
    .XLEN     (XLEN),
    .ZERO_REG (1'b0)
  ) fp_regs (
    .clk     (clk),
    .reset_n (reset_n),
    .we      (fp_we),
    .waddr   (fp_waddr),
    .wdata   (fp_wdata),
    .raddr   (fp_rs_addr),
    .rdata   (fp_rs_data)
  );

endmodule

/* tb/mem_wb_asserts.sv */
/*
  Concurrent assertions on the MEM/WB pipeline register
*/

`timescale 1ns/1ps

module mem_wb_asserts (
  input logic              clk,
  input logic              reset_n,
  input logic              valid_in,
  input logic              valid_out,
  input wb_pkg::reg_addr_t rd_addr_in,
  input wb_pkg::reg_addr_t rd_addr_out,
  input logic              reg_write_out,
  input logic              fp_reg_write_out
);

  // Valid bit is delayed by exactly one cycle
  assert property (@(posedge clk) disable iff (!reset_n)
    $past(reset_n) |-> valid_out == $past(valid_in))
    else $error("valid_out does not follow valid_in");

  assert property (@(posedge clk) disable iff (!reset_n)
    ($past(reset_n) && valid_out) |-> rd_addr_out == $past(rd_addr_in))
    else $error("rd_addr_out does not follow rd_addr_in");

  // No register write straight out of reset
  assert property (@(posedge clk)
    $rose(reset_n) |-> (!reg_write_out && !fp_reg_write_out))
    else $error("write enable high in the first cycle after reset");

endmodule

bind memwb_register mem_wb_asserts u_mem_wb_asserts (
  .clk              (clk),
  .reset_n          (reset_n),
  .valid_in         (valid_in),
  .valid_out        (valid_out),
  .rd_addr_in       (rd_addr_in),
  .rd_addr_out      (rd_addr_out),
  .reg_write_out    (reg_write_out),
  .fp_reg_write_out (fp_reg_write_out)
);

/* tb/mem_wb_tb.sv */
/*
  Testbench for the memory and write-back back end
  Seeded random instruction stream checked against a reference model
*/

`timescale 1ns/1ps

module mem_wb_tb;

  localparam int XLEN          = 32;
  localparam int DMEM_WORDS    = 64;
  localparam int NUM_INSTR     = 2000;
  localparam int RESET_TIMEOUT = 10;
  localparam int DRAIN_TIMEOUT = 8;

  // One write-back in flight, applied one edge after acceptance
  typedef struct packed {
    logic              int_we;
    wb_pkg::reg_addr_t rd;
    logic [31:0]       int_val;
    logic              fp_we;
    wb_pkg::reg_addr_t frd;
    logic [31:0]       fp_val;
    wb_pkg::fflags_t   flags;
  } wb_entry_t;

  logic clk = 1'b0;
  logic reset_n;
  logic in_valid, mem_read, mem_write, reg_write, fp_reg_write, fflags_clear;
  logic [XLEN-1:0] alu_result, store_data, pc_plus_4, mul_div_result;
  logic [XLEN-1:0] fp_result, int_result_fp, int_rs_data, fp_rs_data;
  wb_pkg::mem_size_t mem_size;
  wb_pkg::reg_addr_t rd_addr, fp_rd_addr, int_rs_addr, fp_rs_addr;
  wb_pkg::wb_sel_t   wb_sel;
  wb_pkg::fflags_t   fp_flags, fflags;

  // Reference model state
  logic [31:0]     model_mem [DMEM_WORDS];
  logic [31:0]     model_int [32];
  logic [31:0]     model_fp [32];
  wb_pkg::fflags_t model_flags;
  wb_entry_t       pending [$];
  logic [31:0]     last_store_addr;

  mem_wb_top #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) dut (.*);

  always #20 clk = ~clk;

  initial begin
    reset_n = 1'b0;
    repeat (3) @(posedge clk);
    #2 reset_n = 1'b1;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      report_failure($sformatf("MISMATCH %s expected %08h actual %08h",
                               name, expected, actual));
    end
  endtask

  function automatic int unsigned word_index(input logic [31:0] addr);
    return (addr >> 2) % DMEM_WORDS;
  endfunction

  // Pick the addressed byte or halfword and extend it by the size code
  function automatic logic [31:0] load_value(input logic [31:0] word, input logic [31:0] addr,
                                             input wb_pkg::mem_size_t size);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*addr[1:0] +: 8];
    h = word[16*addr[1] +: 16];
    case (size)
      wb_pkg::SIZE_B:  return {{24{b[7]}}, b};
      wb_pkg::SIZE_BU: return {24'h0, b};
      wb_pkg::SIZE_H:  return {{16{h[15]}}, h};
      wb_pkg::SIZE_HU: return {16'h0, h};
      default:         return word;
    endcase
  endfunction

  task automatic store_model(input logic [31:0] addr, input logic [31:0] data,
                             input wb_pkg::mem_size_t size);
    int unsigned idx;
    idx = word_index(addr);
    case (size)
      wb_pkg::SIZE_B: model_mem[idx][8*addr[1:0] +: 8] = data[7:0];
      wb_pkg::SIZE_H: model_mem[idx][16*addr[1] +: 16] = data[15:0];
      default:        model_mem[idx] = data;
    endcase
  endtask

  // Called right after a rising edge, while the accepted inputs are still driven
  task automatic model_edge();
    wb_entry_t   done;
    wb_entry_t   next;
    logic [31:0] ld;
    done = '0;
    if (pending.size() > 0) done = pending.pop_front();
    if (done.int_we && done.rd != 5'd0) model_int[done.rd] = done.int_val;
    if (done.fp_we) model_fp[done.frd] = done.fp_val;
    if (fflags_clear) model_flags = '0;
    else if (done.fp_we) model_flags = model_flags | done.flags;
    // Load sees memory as it was before this edge
    ld = '0;
    if (mem_read) ld = load_value(model_mem[word_index(alu_result)], alu_result, mem_size);
    if (in_valid && mem_write) store_model(alu_result, store_data, mem_size);
    next.int_we = in_valid && reg_write;
    next.rd     = rd_addr;
    case (wb_sel)
      wb_pkg::WB_ALU:    next.int_val = alu_result;
      wb_pkg::WB_MEM:    next.int_val = ld;
      wb_pkg::WB_PC4:    next.int_val = pc_plus_4;
      wb_pkg::WB_MULDIV: next.int_val = mul_div_result;
      wb_pkg::WB_FPINT:  next.int_val = int_result_fp;
      default:           next.int_val = '0;
    endcase
    next.fp_we  = in_valid && fp_reg_write;
    next.frd    = fp_rd_addr;
    next.fp_val = (wb_sel == wb_pkg::WB_MEM) ? ld : fp_result;
    next.flags  = fp_flags;
    pending.push_back(next);
  endtask

  function automatic logic write_pending();
    return pending.size() > 0 && (pending[0].int_we || pending[0].fp_we);
  endfunction

  // Aligned address that often falls in the word of the last store
  function automatic logic [31:0] mem_address(input wb_pkg::mem_size_t size);
    logic [31:0] base;
    logic [31:0] off;
    if ($urandom_range(0, 2) == 0) base = last_store_addr & ~32'h3;
    else base = 32'($urandom_range(0, 127)) << 2;
    off = 32'($urandom_range(0, 3));
    if (size == wb_pkg::SIZE_H || size == wb_pkg::SIZE_HU) off = off & 32'h2;
    if (size == wb_pkg::SIZE_W) off = '0;
    return base | off;
  endfunction

  function automatic wb_pkg::mem_size_t random_load_size();
    case ($urandom_range(0, 4))
      0:       return wb_pkg::SIZE_B;
      1:       return wb_pkg::SIZE_H;
      2:       return wb_pkg::SIZE_W;
      3:       return wb_pkg::SIZE_BU;
      default: return wb_pkg::SIZE_HU;
    endcase
  endfunction

  task automatic idle_inputs();
    in_valid = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    fp_reg_write = 1'b0;
    fflags_clear = 1'b0;
    alu_result = '0;
    store_data = '0;
    pc_plus_4 = '0;
    mul_div_result = '0;
    fp_result = '0;
    int_result_fp = '0;
    mem_size = wb_pkg::SIZE_W;
    rd_addr = '0;
    fp_rd_addr = '0;
    wb_sel = wb_pkg::WB_ALU;
    fp_flags = '0;
    int_rs_addr = '0;
    fp_rs_addr = '0;
  endtask

  task automatic drive_random();
    int unsigned kind;
    kind = $urandom_range(0, 9);
    idle_inputs();
    in_valid = 1'b1;
    alu_result = $urandom;
    store_data = $urandom;
    pc_plus_4 = $urandom;
    mul_div_result = $urandom;
    fp_result = $urandom;
    int_result_fp = $urandom;
    rd_addr = 5'($urandom);
    fp_rd_addr = 5'($urandom);
    fp_flags = 5'($urandom) & 5'($urandom);
    fflags_clear = ($urandom_range(0, 15) == 0);
    int_rs_addr = 5'($urandom);
    fp_rs_addr = 5'($urandom);
    case (kind)
      0: reg_write = 1'b1;
      1: begin
        reg_write = 1'b1;
        wb_sel = wb_pkg::WB_MEM;
        mem_read = 1'b1;
        mem_size = random_load_size();
        alu_result = mem_address(mem_size);
      end
      2: begin
        mem_write = 1'b1;
        mem_size = 3'($urandom_range(0, 2));
        alu_result = mem_address(mem_size);
        last_store_addr = alu_result;
      end
      3: begin
        reg_write = 1'b1;
        wb_sel = wb_pkg::WB_PC4;
      end
      4: begin
        reg_write = 1'b1;
        wb_sel = wb_pkg::WB_MULDIV;
      end
      5: begin
        reg_write = 1'b1;
        wb_sel = wb_pkg::WB_FPINT;
      end
      6: fp_reg_write = 1'b1;
      7: begin
        fp_reg_write = 1'b1;
        wb_sel = wb_pkg::WB_MEM;
        mem_read = 1'b1;
        alu_result = mem_address(wb_pkg::SIZE_W);
      end
      8: begin
        reg_write = 1'b1;
        wb_sel = 3'($urandom_range(5, 7));
      end
      default: begin
        // Bubble with every enable high
        in_valid = 1'b0;
        reg_write = 1'b1;
        fp_reg_write = 1'b1;
        mem_write = 1'b1;
        mem_size = 3'($urandom_range(0, 2));
        alu_result = mem_address(mem_size);
        wb_sel = 3'($urandom);
      end
    endcase
  endtask

  task automatic check_state(input string tag);
    check_value($sformatf("%s int x%0d", tag, int_rs_addr), model_int[int_rs_addr], int_rs_data);
    check_value($sformatf("%s fp f%0d", tag, fp_rs_addr), model_fp[fp_rs_addr], fp_rs_data);
    check_value($sformatf("%s fflags", tag), 32'(model_flags), 32'(fflags));
  endtask

  task automatic sweep_all(input string tag);
    for (int r = 0; r < 32; r++) begin
      int_rs_addr = 5'(r);
      fp_rs_addr  = 5'(r);
      #1;
      check_state(tag);
    end
  endtask

  initial begin
    int n;
    void'($urandom(32'h79ca));
    idle_inputs();
    for (int i = 0; i < DMEM_WORDS; i++) model_mem[i] = '0;
    for (int i = 0; i < 32; i++) begin
      model_int[i] = '0;
      model_fp[i]  = '0;
    end
    model_flags = '0;
    last_store_addr = '0;
    n = 0;
    while (reset_n !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > RESET_TIMEOUT) report_failure("reset was never released");
    end
    #2;
    sweep_all("reset");
    for (int i = 0; i < NUM_INSTR; i++) begin
      @(posedge clk);
      model_edge();
      #2;
      drive_random();
      #1;
      check_state("random");
    end
    // Let the last instruction reach the register files
    n = 0;
    do begin
      @(posedge clk);
      model_edge();
      #2;
      idle_inputs();
      n++;
      if (n > DRAIN_TIMEOUT) report_failure("pipeline did not drain in time");
    end while (write_pending());
    #1;
    sweep_all("final");
    $display("Regression passed");
    $finish;
  end

endmodule

/* compile.f */
rtl/wb_pkg.sv
rtl/mem_stage.sv
rtl/memwb_register.sv
rtl/wb_stage.sv
rtl/reg_file.sv
rtl/mem_wb_top.sv
tb/mem_wb_asserts.sv
tb/mem_wb_tb.sv

/* Makefile */
# Verilator simulation of the memory and write-back back end

VERILATOR ?= verilator
TOP       ?= mem_wb_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
